//--- hdl/ex_pkg.sv
`default_nettype none

package ex_pkg;

    // datapath and register file sizing
    localparam int XLEN    = 32;
    localparam int NREGS   = 32;
    localparam int ROBID_W = 5;
    localparam int REGIDX_W = $clog2(NREGS);
    // shift amount comes from the low bits of operand b
    localparam int SHAMT_W = $clog2(XLEN);

    typedef logic [XLEN-1:0]     t_xlen;
    typedef logic [XLEN-1:0]     t_addr;
    typedef logic [REGIDX_W-1:0] t_regidx;
    typedef logic [ROBID_W-1:0]  t_robid;

    // micro-op encoding, alu ops first and branches after
    typedef enum logic [4:0] {
        UOP_ADD  = 5'd0,
        UOP_SUB  = 5'd1,
        UOP_AND  = 5'd2,
        UOP_OR   = 5'd3,
        UOP_XOR  = 5'd4,
        UOP_SLT  = 5'd5,
        UOP_SLTU = 5'd6,
        UOP_SLL  = 5'd7,
        UOP_SRL  = 5'd8,
        UOP_SRA  = 5'd9,
        UOP_BEQ  = 5'd16,
        UOP_BNE  = 5'd17,
        UOP_BLT  = 5'd18,
        UOP_BGE  = 5'd19,
        UOP_BLTU = 5'd20,
        UOP_BGEU = 5'd21
    } t_uop;

    // true for the six conditional branches
    function automatic logic is_branch(t_uop uop);
        logic br;
        br = 1'b0;
        case (uop)
            UOP_BEQ,
            UOP_BNE,
            UOP_BLT,
            UOP_BGE,
            UOP_BLTU,
            UOP_BGEU: br = 1'b1;
            default:  br = 1'b0;
        endcase
        return br;
    endfunction

endpackage

`default_nettype wire

//--- hdl/ex_op_if.sv
`default_nettype none

// one operand-ready micro-op from control to the execution units
interface ex_op_if (
    input wire logic clk,
    input wire logic rst_n
);

    logic           valid;
    ex_pkg::t_uop   uop;
    ex_pkg::t_addr  pc;
    ex_pkg::t_xlen  imm;
    ex_pkg::t_xlen  src1;
    ex_pkg::t_xlen  src2;
    logic           use_imm;
    ex_pkg::t_robid robid;

    modport ctrl (
        output valid, uop, pc, imm, src1, src2, use_imm, robid
    );

    // clk and rst_n are only here for unit-side checkers
    modport unit (
        input clk, rst_n,
        input valid, uop, pc, imm, src1, src2, use_imm, robid
    );

endinterface

`default_nettype wire

//--- hdl/ex_ctrl.sv
`default_nettype none

module ex_ctrl (
    input  wire logic             clk,
    input  wire logic             rst_n,

    input  wire logic             issue_valid,
    input  wire ex_pkg::t_uop     issue_uop,
    input  wire ex_pkg::t_addr    issue_pc,
    input  wire ex_pkg::t_xlen    issue_imm,
    input  wire ex_pkg::t_regidx  issue_rs1,
    input  wire ex_pkg::t_regidx  issue_rs2,
    input  wire ex_pkg::t_regidx  issue_rd,
    input  wire logic             issue_use_imm,
    input  wire ex_pkg::t_robid   issue_robid,

    output ex_pkg::t_regidx       rf_rs1,
    output ex_pkg::t_regidx       rf_rs2,
    input  wire ex_pkg::t_xlen    rf_data1,
    input  wire ex_pkg::t_xlen    rf_data2,
    output logic                  rf_wen,
    output ex_pkg::t_regidx       rf_waddr,
    output ex_pkg::t_xlen         rf_wdata,

    ex_op_if.ctrl                 op,

    input  wire ex_pkg::t_xlen    alu_data,
    input  wire logic             taken,
    input  wire ex_pkg::t_addr    true_target,
    input  wire logic             mispred,

    output logic                  res_valid,
    output ex_pkg::t_robid        res_robid,
    output ex_pkg::t_regidx       res_rd,
    output ex_pkg::t_xlen         res_data,
    output logic                  mispred_valid,
    output ex_pkg::t_addr         mispred_target,
    output ex_pkg::t_robid        mispred_robid
);

    typedef enum logic {
        RUN,
        REDIRECT
    } t_state;

    t_state        state;
    ex_pkg::t_addr redir_target;
    logic          on_path;
    logic          is_br;

    // wrong-path filter: after a redirect only the target pc gets through
    assign on_path = issue_valid && (state == RUN || issue_pc == redir_target);
    assign is_br   = ex_pkg::is_branch(issue_uop);

    assign rf_rs1 = issue_rs1;
    assign rf_rs2 = issue_rs2;

    assign op.valid   = on_path;
    assign op.uop     = issue_uop;
    assign op.pc      = issue_pc;
    assign op.imm     = issue_imm;
    assign op.src1    = rf_data1;
    assign op.src2    = rf_data2;
    assign op.use_imm = issue_use_imm;
    assign op.robid   = issue_robid;

    // writeback lands on the same edge that registers the result
    assign rf_wen   = on_path && !is_br && (issue_rd != '0);
    assign rf_waddr = issue_rd;
    assign rf_wdata = alu_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= RUN;
            res_valid     <= 1'b0;
            mispred_valid <= 1'b0;
        end else begin
            res_valid     <= on_path;
            mispred_valid <= mispred;
            if (taken) begin
                state <= REDIRECT;
            end else if (state == REDIRECT && on_path) begin
                // first micro-op at the target resumes normal flow
                state <= RUN;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (taken) begin
            redir_target <= true_target;
        end
        res_robid      <= issue_robid;
        res_rd         <= is_br ? '0 : issue_rd;
        res_data       <= is_br ? true_target : alu_data;
        mispred_target <= true_target;
        mispred_robid  <= issue_robid;
    end

    // a dropped wrong-path micro-op never reaches the register file
    a_drop_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        (state == REDIRECT && issue_valid && issue_pc != redir_target) |-> !rf_wen);

    // branch unit flags a mispredict only for a taken branch of ours
    a_mispred_taken: assert property (@(posedge clk) disable iff (!rst_n)
        mispred |-> (taken && on_path && is_br));

endmodule

`default_nettype wire

//--- hdl/ex_regfile.sv
`default_nettype none

module ex_regfile (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire ex_pkg::t_regidx rs1,
    input  wire ex_pkg::t_regidx rs2,
    output ex_pkg::t_xlen        data1,
    output ex_pkg::t_xlen        data2,
    input  wire logic            wen,
    input  wire ex_pkg::t_regidx waddr,
    input  wire ex_pkg::t_xlen   wdata
);

    // x1..x31 only, x0 has no storage
    ex_pkg::t_xlen regs [1:ex_pkg::NREGS-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < ex_pkg::NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign data1 = (rs1 == '0) ? '0 : regs[rs1];
    assign data2 = (rs2 == '0) ? '0 : regs[rs2];

    // x0 reads as zero on both ports, even right after a write aimed at it
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((rs1 == '0) |-> (data1 == '0)) and ((rs2 == '0) |-> (data2 == '0)));

endmodule

`default_nettype wire

//--- hdl/ex_alu.sv
`default_nettype none

module ex_alu (
    ex_op_if.unit         op,
    output ex_pkg::t_xlen alu_data
);

    ex_pkg::t_xlen                 opb;
    logic [ex_pkg::SHAMT_W-1:0]    shamt;
    logic                          lt_s;
    logic                          lt_u;

    // operand b is the immediate or rs2
    assign opb   = op.use_imm ? op.imm : op.src2;
    assign shamt = opb[ex_pkg::SHAMT_W-1:0];
    assign lt_s  = $signed(op.src1) < $signed(opb);
    assign lt_u  = op.src1 < opb;

    always_comb begin
        alu_data = '0;
        if (op.valid) begin
            case (op.uop)
                ex_pkg::UOP_ADD:  alu_data = op.src1 + opb;
                ex_pkg::UOP_SUB:  alu_data = op.src1 - opb;
                ex_pkg::UOP_AND:  alu_data = op.src1 & opb;
                ex_pkg::UOP_OR:   alu_data = op.src1 | opb;
                ex_pkg::UOP_XOR:  alu_data = op.src1 ^ opb;
                ex_pkg::UOP_SLT:  alu_data = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
                ex_pkg::UOP_SLTU: alu_data = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
                ex_pkg::UOP_SLL:  alu_data = op.src1 << shamt;
                ex_pkg::UOP_SRL:  alu_data = op.src1 >> shamt;
                // arithmetic shift keeps the sign bit
                ex_pkg::UOP_SRA:  alu_data = ex_pkg::t_xlen'($signed(op.src1) >>> shamt);
                // branches belong to the branch unit
                default:          alu_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/ex_branch.sv
`default_nettype none

module ex_branch (
    ex_op_if.unit         op,
    output logic          taken,
    output ex_pkg::t_addr true_target,
    output logic          mispred
);

    logic          br_valid;
    logic          cond;
    ex_pkg::t_addr tkn_tgt;
    ex_pkg::t_addr pc_next;

    assign br_valid = op.valid && ex_pkg::is_branch(op.uop);

    // branches always compare rs1 with rs2, never the immediate
    always_comb begin
        cond = 1'b0;
        case (op.uop)
            ex_pkg::UOP_BEQ:  cond = op.src1 == op.src2;
            ex_pkg::UOP_BNE:  cond = op.src1 != op.src2;
            ex_pkg::UOP_BLT:  cond = $signed(op.src1) <  $signed(op.src2);
            ex_pkg::UOP_BGE:  cond = $signed(op.src1) >= $signed(op.src2);
            ex_pkg::UOP_BLTU: cond = op.src1 <  op.src2;
            ex_pkg::UOP_BGEU: cond = op.src1 >= op.src2;
            default:          cond = 1'b0;
        endcase
    end

    assign tkn_tgt = op.pc + op.imm;
    assign pc_next = op.pc + ex_pkg::t_addr'(4);

    assign taken       = br_valid && cond;
    assign true_target = taken ? tkn_tgt : pc_next;

    // prediction is always fall-through
    assign mispred = br_valid && (true_target != pc_next);

    a_mispred_valid_br: assert property (@(posedge op.clk) disable iff (!op.rst_n)
        mispred |-> (op.valid && ex_pkg::is_branch(op.uop)));

endmodule

`default_nettype wire

//--- hdl/ex_top.sv
`default_nettype none

module ex_top (
    input  wire logic            clk,
    input  wire logic            rst_n,

    input  wire logic            issue_valid,
    input  wire ex_pkg::t_uop    issue_uop,
    input  wire ex_pkg::t_addr   issue_pc,
    input  wire ex_pkg::t_xlen   issue_imm,
    input  wire ex_pkg::t_regidx issue_rs1,
    input  wire ex_pkg::t_regidx issue_rs2,
    input  wire ex_pkg::t_regidx issue_rd,
    input  wire logic            issue_use_imm,
    input  wire ex_pkg::t_robid  issue_robid,

    output logic                 res_valid,
    output ex_pkg::t_robid       res_robid,
    output ex_pkg::t_regidx      res_rd,
    output ex_pkg::t_xlen        res_data,
    output logic                 mispred_valid,
    output ex_pkg::t_addr        mispred_target,
    output ex_pkg::t_robid       mispred_robid
);

    // register file traffic
    ex_pkg::t_regidx rf_rs1;
    ex_pkg::t_regidx rf_rs2;
    ex_pkg::t_xlen   rf_data1;
    ex_pkg::t_xlen   rf_data2;
    logic            rf_wen;
    ex_pkg::t_regidx rf_waddr;
    ex_pkg::t_xlen   rf_wdata;

    // unit answers
    ex_pkg::t_xlen   alu_data;
    logic            taken;
    ex_pkg::t_addr   true_target;
    logic            mispred;

    ex_op_if op_if (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ex_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .issue_uop      (issue_uop),
        .issue_pc       (issue_pc),
        .issue_imm      (issue_imm),
        .issue_rs1      (issue_rs1),
        .issue_rs2      (issue_rs2),
        .issue_rd       (issue_rd),
        .issue_use_imm  (issue_use_imm),
        .issue_robid    (issue_robid),
        .rf_rs1         (rf_rs1),
        .rf_rs2         (rf_rs2),
        .rf_data1       (rf_data1),
        .rf_data2       (rf_data2),
        .rf_wen         (rf_wen),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .op             (op_if.ctrl),
        .alu_data       (alu_data),
        .taken          (taken),
        .true_target    (true_target),
        .mispred        (mispred),
        .res_valid      (res_valid),
        .res_robid      (res_robid),
        .res_rd         (res_rd),
        .res_data       (res_data),
        .mispred_valid  (mispred_valid),
        .mispred_target (mispred_target),
        .mispred_robid  (mispred_robid)
    );

    ex_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .rs1   (rf_rs1),
        .rs2   (rf_rs2),
        .data1 (rf_data1),
        .data2 (rf_data2),
        .wen   (rf_wen),
        .waddr (rf_waddr),
        .wdata (rf_wdata)
    );

    ex_alu u_alu (
        .op       (op_if.unit),
        .alu_data (alu_data)
    );

    ex_branch u_branch (
        .op          (op_if.unit),
        .taken       (taken),
        .true_target (true_target),
        .mispred     (mispred)
    );

endmodule

`default_nettype wire

//--- tb/ex_tb.sv
`default_nettype none

module ex_tb;

    logic            clk;
    logic            rst_n;
    logic            issue_valid;
    ex_pkg::t_uop    issue_uop;
    ex_pkg::t_addr   issue_pc;
    ex_pkg::t_xlen   issue_imm;
    ex_pkg::t_regidx issue_rs1;
    ex_pkg::t_regidx issue_rs2;
    ex_pkg::t_regidx issue_rd;
    logic            issue_use_imm;
    ex_pkg::t_robid  issue_robid;

    logic            res_valid;
    ex_pkg::t_robid  res_robid;
    ex_pkg::t_regidx res_rd;
    ex_pkg::t_xlen   res_data;
    logic            mispred_valid;
    ex_pkg::t_addr   mispred_target;
    ex_pkg::t_robid  mispred_robid;

    // reference state
    ex_pkg::t_xlen   model_regs [0:31];
    logic            redir;
    ex_pkg::t_addr   redir_tgt;

    integer          seed = 32'h542d_734d;
    string           test_name;
    int              errors;
    int              test_start_errors;
    int              tests_run;
    int              tests_failed;

    ex_top uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .issue_uop      (issue_uop),
        .issue_pc       (issue_pc),
        .issue_imm      (issue_imm),
        .issue_rs1      (issue_rs1),
        .issue_rs2      (issue_rs2),
        .issue_rd       (issue_rd),
        .issue_use_imm  (issue_use_imm),
        .issue_robid    (issue_robid),
        .res_valid      (res_valid),
        .res_robid      (res_robid),
        .res_rd         (res_rd),
        .res_data       (res_data),
        .mispred_valid  (mispred_valid),
        .mispred_target (mispred_target),
        .mispred_robid  (mispred_robid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_data(input string name, input ex_pkg::t_xlen exp,
                              input ex_pkg::t_xlen act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input ex_pkg::t_addr exp,
                              input ex_pkg::t_addr act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_robid(input string name, input ex_pkg::t_robid exp,
                               input ex_pkg::t_robid act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input ex_pkg::t_regidx exp,
                             input ex_pkg::t_regidx act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected x%0d, actual x%0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic ex_pkg::t_xlen model_alu(ex_pkg::t_uop u, ex_pkg::t_xlen a,
                                                ex_pkg::t_xlen b);
        case (u)
            ex_pkg::UOP_ADD:  return a + b;
            ex_pkg::UOP_SUB:  return a - b;
            ex_pkg::UOP_AND:  return a & b;
            ex_pkg::UOP_OR:   return a | b;
            ex_pkg::UOP_XOR:  return a ^ b;
            ex_pkg::UOP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ex_pkg::UOP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ex_pkg::UOP_SLL:  return a << b[4:0];
            ex_pkg::UOP_SRL:  return a >> b[4:0];
            ex_pkg::UOP_SRA:  return ex_pkg::t_xlen'($signed(a) >>> b[4:0]);
            default:          return '0;
        endcase
    endfunction

    function automatic logic model_cond(ex_pkg::t_uop u, ex_pkg::t_xlen a, ex_pkg::t_xlen b);
        case (u)
            ex_pkg::UOP_BEQ:  return a == b;
            ex_pkg::UOP_BNE:  return a != b;
            ex_pkg::UOP_BLT:  return $signed(a) < $signed(b);
            ex_pkg::UOP_BGE:  return $signed(a) >= $signed(b);
            ex_pkg::UOP_BLTU: return a < b;
            default:          return a >= b;
        endcase
    endfunction

    // stay on the predicted path unless a redirect is still owed
    function automatic ex_pkg::t_addr next_pc();
        return redir ? redir_tgt : (ex_pkg::t_addr'($random(seed)) & 32'hffff_fffc);
    endfunction

    // drive one micro-op on the falling edge and check its result one cycle later
    task automatic issue_op(input ex_pkg::t_uop u, input ex_pkg::t_addr pc,
                            input ex_pkg::t_xlen imm, input ex_pkg::t_regidx rs1,
                            input ex_pkg::t_regidx rs2, input ex_pkg::t_regidx rd,
                            input logic use_imm);
        logic           drop;
        logic           br;
        logic           tk;
        ex_pkg::t_xlen  b;
        ex_pkg::t_xlen  exp_data;
        ex_pkg::t_addr  nxt;
        ex_pkg::t_robid rid;
        rid = ex_pkg::t_robid'($random(seed));
        issue_valid   = 1'b1;
        issue_uop     = u;
        issue_pc      = pc;
        issue_imm     = imm;
        issue_rs1     = rs1;
        issue_rs2     = rs2;
        issue_rd      = rd;
        issue_use_imm = use_imm;
        issue_robid   = rid;
        br   = (u >= ex_pkg::UOP_BEQ);
        drop = redir && (pc != redir_tgt);
        b    = use_imm ? imm : model_regs[rs2];
        tk   = br && model_cond(u, model_regs[rs1], model_regs[rs2]);
        nxt  = tk ? pc + imm : pc + 32'd4;
        exp_data = br ? nxt : model_alu(u, model_regs[rs1], b);
        @(posedge clk);
        @(negedge clk);
        issue_valid = 1'b0;
        check_bit({test_name, " res_valid"}, !drop, res_valid);
        check_bit({test_name, " mispred_valid"}, !drop && tk, mispred_valid);
        if (!drop) begin
            check_robid({test_name, " res_robid"}, rid, res_robid);
            check_reg({test_name, " res_rd"}, br ? 5'd0 : rd, res_rd);
            check_data({test_name, " res_data"}, exp_data, res_data);
            if (tk) begin
                check_addr({test_name, " mispred_target"}, nxt, mispred_target);
                check_robid({test_name, " mispred_robid"}, rid, mispred_robid);
            end
            if (!br && rd != 5'd0) begin
                model_regs[rd] = exp_data;
            end
            redir     = tk;
            redir_tgt = nxt;
        end
    endtask

    task automatic load_reg(input ex_pkg::t_regidx r, input ex_pkg::t_xlen v);
        issue_op(ex_pkg::UOP_ADD, next_pc(), v, 5'd0, 5'd0, r, 1'b1);
    endtask

    // result of x[r] + 0 shows the register's value
    task automatic read_reg(input ex_pkg::t_regidx r);
        issue_op(ex_pkg::UOP_ADD, next_pc(), 32'd0, r, 5'd0, 5'd0, 1'b1);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", test_name, errors - test_start_errors);
        end
    endtask

    // watchdog so a stuck run still ends
    initial begin : watchdog
        int cycles;
        for (cycles = 0; cycles < 20000; cycles++) begin
            @(posedge clk);
        end
        $display("timeout: the run did not complete within 20000 cycles");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        ex_pkg::t_addr  tgt;
        ex_pkg::t_xlen  v;
        ex_pkg::t_regidx r;
        ex_pkg::t_regidx prev;
        int cnt;
        rst_n = 1'b0;
        issue_valid = 1'b0;
        issue_uop = ex_pkg::UOP_ADD;
        issue_pc = '0;
        issue_imm = '0;
        issue_rs1 = '0;
        issue_rs2 = '0;
        issue_rd = '0;
        issue_use_imm = 1'b0;
        issue_robid = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        redir = 1'b0;
        redir_tgt = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        cnt = 0;
        while (cnt < 16) begin
            @(posedge clk);
            cnt++;
        end
        @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_idle");
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_bit({test_name, " res_valid"}, 1'b0, res_valid);
            check_bit({test_name, " mispred_valid"}, 1'b0, mispred_valid);
        end
        load_reg(5'd3, 32'h1234_5678);
        end_test();

        start_test("random_alu");
        for (int i = 0; i < 200; i++) begin
            issue_op(ex_pkg::t_uop'(5'($unsigned($random(seed)) % 10)), next_pc(),
                     ex_pkg::t_xlen'($random(seed)), ex_pkg::t_regidx'($random(seed)),
                     ex_pkg::t_regidx'($random(seed)), ex_pkg::t_regidx'($random(seed)),
                     1'($random(seed)));
        end
        load_reg(5'd0, 32'hdead_beef);
        read_reg(5'd0);
        end_test();

        start_test("dependent_chain");
        prev = 5'd1;
        load_reg(prev, ex_pkg::t_xlen'($random(seed)));
        for (int i = 0; i < 40; i++) begin
            r = ex_pkg::t_regidx'(1 + $unsigned($random(seed)) % 31);
            issue_op(ex_pkg::t_uop'(5'($unsigned($random(seed)) % 10)), next_pc(),
                     ex_pkg::t_xlen'($random(seed)), prev, 5'd0, r, 1'b1);
            prev = r;
        end
        end_test();

        start_test("branches");
        v = ex_pkg::t_xlen'($random(seed));
        load_reg(5'd1, v);
        load_reg(5'd2, v);
        load_reg(5'd3, v ^ 32'h8000_0000);
        load_reg(5'd4, ex_pkg::t_xlen'($random(seed)));
        // a branch carries a live rd that must come back as x0 and stay unwritten
        for (int c = 0; c < 6; c++) begin
            issue_op(ex_pkg::t_uop'(5'(16 + c)), next_pc(), 32'h0000_0100, 5'd1, 5'd2, 5'd4, 1'b0);
            issue_op(ex_pkg::t_uop'(5'(16 + c)), next_pc(), 32'hffff_ff80, 5'd1, 5'd3, 5'd2, 1'b0);
            issue_op(ex_pkg::t_uop'(5'(16 + c)), next_pc(), 32'h0000_0040, 5'd3, 5'd1, 5'd1, 1'b0);
        end
        for (int i = 0; i < 80; i++) begin
            issue_op(ex_pkg::t_uop'(5'(16 + $unsigned($random(seed)) % 6)), next_pc(),
                     ex_pkg::t_xlen'($random(seed)) & 32'hffff_fffe,
                     ex_pkg::t_regidx'(1 + $unsigned($random(seed)) % 4),
                     ex_pkg::t_regidx'(1 + $unsigned($random(seed)) % 4),
                     ex_pkg::t_regidx'($random(seed)), 1'b0);
        end
        end_test();

        start_test("redirect");
        issue_op(ex_pkg::UOP_BEQ, next_pc(), 32'h0000_0040, 5'd1, 5'd2, 5'd0, 1'b0);
        tgt = redir_tgt;
        for (int k = 1; k <= 3; k++) begin
            issue_op(ex_pkg::UOP_ADD, tgt + 32'(4 * k), ex_pkg::t_xlen'($random(seed)),
                     5'd0, 5'd0, ex_pkg::t_regidx'(4 + k), 1'b1);
        end
        read_reg(5'd5);
        read_reg(5'd6);
        read_reg(5'd7);
        end_test();

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hdl/ex_pkg.sv
hdl/ex_op_if.sv
hdl/ex_ctrl.sv
hdl/ex_regfile.sv
hdl/ex_alu.sv
hdl/ex_branch.sv
hdl/ex_top.sv
tb/ex_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f all.f --top-module ex_tb -o ex_sim
out=$(./obj_dir/ex_sim)
echo "$out"
if echo "$out" | grep -qxF "Finished with no errors"; then
    exit 0
fi
exit 1
